//--- axis_beat_counter.sv
`timescale 1ns/1ps

module axis_beat_counter #(
  parameter int START_COUNT = 32,
  parameter int BURST_WORDS = 8,
  localparam int CNT_MAX = (START_COUNT > BURST_WORDS) ? START_COUNT : BURST_WORDS,
  localparam int CNT_WIDTH = $clog2(CNT_MAX + 1)
) (
  input  logic                     M_AXIS_ACLK,
  input  logic                     M_AXIS_ARESETN,
  input  axis_gen_pkg::count_ctrl_t count_ctrl,
  output logic [CNT_WIDTH-1:0]     count
);

  // Shared between the start delay and the word index of a burst
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      count <= '0;
    end else if (count_ctrl.clear) begin
      count <= '0;
    end else if (count_ctrl.step) begin
      count <= count + 1'b1;
    end
  end

endmodule

//--- axis_burst_fsm.sv
`timescale 1ns/1ps

module axis_burst_fsm #(
  parameter int START_COUNT = 32,
  parameter int BURST_WORDS = 8,
  localparam int CNT_MAX = (START_COUNT > BURST_WORDS) ? START_COUNT : BURST_WORDS,
  localparam int CNT_WIDTH = $clog2(CNT_MAX + 1)
) (
  input  logic                       M_AXIS_ACLK,
  input  logic                       M_AXIS_ARESETN,
  input  logic                       can_load,
  input  logic                       burst_sent,
  input  logic [CNT_WIDTH-1:0]       count,
  output axis_gen_pkg::count_ctrl_t  count_ctrl,
  output axis_gen_pkg::beat_req_t    beat_req,
  output axis_gen_pkg::burst_state_t state
);

  import axis_gen_pkg::*;

  burst_state_t state_q;
  burst_state_t state_d;
  logic         beats_left;
  logic         delay_done;

  assign delay_done = (count == CNT_WIDTH'(START_COUNT - 1));

  // In SEND the counter holds the number of beats already issued
  assign beats_left = (count != CNT_WIDTH'(BURST_WORDS));

  always_comb begin
    state_d    = state_q;
    count_ctrl = '0;
    beat_req   = '0;
    case (state_q)
      IDLE: begin
        count_ctrl.clear = 1'b1;
        state_d          = START_WAIT;
      end
      START_WAIT: begin
        if (delay_done) begin
          count_ctrl.clear = 1'b1;
          state_d          = SEND;
        end else begin
          count_ctrl.step = 1'b1;
        end
      end
      SEND: begin
        if (beats_left) begin
          if (can_load) begin
            beat_req.load   = 1'b1;
            beat_req.last   = (count == CNT_WIDTH'(BURST_WORDS - 1));
            count_ctrl.step = 1'b1;
          end
        end else if (burst_sent) begin
          // With all beats issued the FSM leaves only once the TLAST beat is accepted
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state = state_q;

endmodule

//--- axis_gen_pkg.sv
package axis_gen_pkg;

  // Sequencer states of the traffic generator
  typedef enum logic [1:0] {
    IDLE       = 2'b00,
    START_WAIT = 2'b01,
    SEND       = 2'b10
  } burst_state_t;

  // Control from the FSM to the shared counter
  // clear wins over step when both are set
  typedef struct packed {
    logic clear;
    logic step;
  } count_ctrl_t;

  // One beat request per cycle at most
  // load is only raised while the output stage can take a beat
  typedef struct packed {
    logic load;
    logic last;
  } beat_req_t;

endpackage

//--- axis_output_register.sv
`timescale 1ns/1ps

module axis_output_register #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                    M_AXIS_ACLK,
  input  logic                    M_AXIS_ARESETN,
  input  axis_gen_pkg::beat_req_t beat_req,
  input  logic [DATA_WIDTH-1:0]   word,
  input  logic                    M_AXIS_TREADY,
  output logic                    M_AXIS_TVALID,
  output logic [DATA_WIDTH-1:0]   M_AXIS_TDATA,
  output logic                    M_AXIS_TLAST,
  output logic                    can_load,
  output logic                    burst_sent
);

  logic                  valid_q;
  logic                  last_q;
  logic [DATA_WIDTH-1:0] data_q;

  // Empty now, or the held beat leaves on this edge
  assign can_load = !valid_q || M_AXIS_TREADY;

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else if (beat_req.load) begin
      valid_q <= 1'b1;
      last_q  <= beat_req.last;
    end else if (M_AXIS_TREADY) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (beat_req.load) begin
      data_q <= word;
    end
  end

  assign burst_sent = valid_q && M_AXIS_TREADY && last_q;

  assign M_AXIS_TVALID = valid_q;
  assign M_AXIS_TDATA  = data_q;
  assign M_AXIS_TLAST  = last_q;

endmodule

//--- axis_pattern_source.sv
`timescale 1ns/1ps

module axis_pattern_source #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                    M_AXIS_ACLK,
  input  logic                    M_AXIS_ARESETN,
  input  axis_gen_pkg::beat_req_t beat_req,
  output logic [DATA_WIDTH-1:0]   word
);

  localparam int HALF_WIDTH = DATA_WIDTH / 2;

  logic [HALF_WIDTH-1:0] burst_num;
  logic [HALF_WIDTH-1:0] word_idx;

  // Both fields wrap at their width
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      burst_num <= '0;
      word_idx  <= '0;
    end else if (beat_req.load) begin
      if (beat_req.last) begin
        burst_num <= burst_num + 1'b1;
        word_idx  <= '0;
      end else begin
        word_idx <= word_idx + 1'b1;
      end
    end
  end

  // Sampled by the output stage on the same edge that advances the fields
  assign word = {burst_num, word_idx};

endmodule

//--- axis_stream_master.sv
`timescale 1ns/1ps

module axis_stream_master #(
  parameter int DATA_WIDTH  = 32,
  parameter int START_COUNT = 32,
  parameter int BURST_WORDS = 8
) (
  input  logic                    M_AXIS_ACLK,
  input  logic                    M_AXIS_ARESETN,
  output logic                    M_AXIS_TVALID,
  output logic [DATA_WIDTH-1:0]   M_AXIS_TDATA,
  output logic [DATA_WIDTH/8-1:0] M_AXIS_TSTRB,
  output logic                    M_AXIS_TLAST,
  input  logic                    M_AXIS_TREADY
);

  import axis_gen_pkg::*;

  localparam int CNT_MAX = (START_COUNT > BURST_WORDS) ? START_COUNT : BURST_WORDS;
  localparam int CNT_WIDTH = $clog2(CNT_MAX + 1);

  count_ctrl_t           count_ctrl;
  beat_req_t             beat_req;
  burst_state_t          state;
  logic [CNT_WIDTH-1:0]  count;
  logic [DATA_WIDTH-1:0] word;
  logic                  can_load;
  logic                  burst_sent;

  axis_burst_fsm #(
    .START_COUNT (START_COUNT),
    .BURST_WORDS (BURST_WORDS)
  ) u_fsm (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .can_load       (can_load),
    .burst_sent     (burst_sent),
    .count          (count),
    .count_ctrl     (count_ctrl),
    .beat_req       (beat_req),
    .state          (state)
  );

  axis_beat_counter #(
    .START_COUNT (START_COUNT),
    .BURST_WORDS (BURST_WORDS)
  ) u_counter (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .count_ctrl     (count_ctrl),
    .count          (count)
  );

  axis_pattern_source #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_pattern (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .beat_req       (beat_req),
    .word           (word)
  );

  axis_output_register #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_out (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .beat_req       (beat_req),
    .word           (word),
    .M_AXIS_TREADY  (M_AXIS_TREADY),
    .M_AXIS_TVALID  (M_AXIS_TVALID),
    .M_AXIS_TDATA   (M_AXIS_TDATA),
    .M_AXIS_TLAST   (M_AXIS_TLAST),
    .can_load       (can_load),
    .burst_sent     (burst_sent)
  );

  // Every byte lane is a data byte
  assign M_AXIS_TSTRB = '1;

endmodule

//--- axis_stream_master_properties.sv
`timescale 1ns/1ps

module axis_stream_master_properties #(
  parameter int DATA_WIDTH  = 32,
  parameter int START_COUNT = 32
) (
  input logic                       M_AXIS_ACLK,
  input logic                       M_AXIS_ARESETN,
  input logic                       M_AXIS_TVALID,
  input logic [DATA_WIDTH-1:0]      M_AXIS_TDATA,
  input logic [DATA_WIDTH/8-1:0]    M_AXIS_TSTRB,
  input logic                       M_AXIS_TLAST,
  input logic                       M_AXIS_TREADY,
  input axis_gen_pkg::burst_state_t state
);

  import axis_gen_pkg::*;

  // Minimum number of idle edges between a TLAST transfer and the next TVALID
  localparam int GAP_CYCLES = START_COUNT + 1;

  int unsigned fail_count = 0;

  // Covers every reset edge and the first edge after release
  reset_quiet: assert property (@(posedge M_AXIS_ACLK)
    !M_AXIS_ARESETN |=> !M_AXIS_TVALID && !M_AXIS_TLAST)
    else begin
      $error("TVALID or TLAST was high during reset or on the first edge after it");
      fail_count = fail_count + 1;
    end

  reset_state: assert property (@(posedge M_AXIS_ACLK)
    !M_AXIS_ARESETN |=> state == IDLE)
    else begin
      $error("The FSM was not in IDLE after a reset edge");
      fail_count = fail_count + 1;
    end

  hold_on_stall: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    M_AXIS_TVALID && !M_AXIS_TREADY
      |=> M_AXIS_TVALID && $stable(M_AXIS_TDATA) && $stable(M_AXIS_TLAST))
    else begin
      $error("A stalled beat changed or was dropped before it was accepted");
      fail_count = fail_count + 1;
    end

  gap_after_last: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    M_AXIS_TVALID && M_AXIS_TREADY && M_AXIS_TLAST |=> !M_AXIS_TVALID [*GAP_CYCLES])
    else begin
      $error("TVALID rose too soon after the end of a burst");
      fail_count = fail_count + 1;
    end

  // A beat that leaves mid-burst is always replaced on the same edge
  back_to_back: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    (M_AXIS_TVALID && M_AXIS_TREADY && !M_AXIS_TLAST) ##1 M_AXIS_TREADY |-> M_AXIS_TVALID)
    else begin
      $error("A burst had a bubble although TREADY stayed high");
      fail_count = fail_count + 1;
    end

  valid_in_send: assert property (@(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    M_AXIS_TVALID |-> state == SEND)
    else begin
      $error("TVALID was high while the FSM was not sending");
      fail_count = fail_count + 1;
    end

  strobe_full: assert property (@(posedge M_AXIS_ACLK) M_AXIS_TSTRB == '1)
    else begin
      $error("TSTRB was not all ones");
      fail_count = fail_count + 1;
    end

endmodule

bind axis_stream_master axis_stream_master_properties #(
  .DATA_WIDTH  (DATA_WIDTH),
  .START_COUNT (START_COUNT)
) u_props (
  .M_AXIS_ACLK    (M_AXIS_ACLK),
  .M_AXIS_ARESETN (M_AXIS_ARESETN),
  .M_AXIS_TVALID  (M_AXIS_TVALID),
  .M_AXIS_TDATA   (M_AXIS_TDATA),
  .M_AXIS_TSTRB   (M_AXIS_TSTRB),
  .M_AXIS_TLAST   (M_AXIS_TLAST),
  .M_AXIS_TREADY  (M_AXIS_TREADY),
  .state          (state)
);

//--- flist.f
axis_gen_pkg.sv
axis_beat_counter.sv
axis_burst_fsm.sv
axis_pattern_source.sv
axis_output_register.sv
axis_stream_master.sv
axis_stream_master_properties.sv
tb_axis_stream_master.sv

//--- tb_axis_stream_master.sv
`timescale 1ns/1ps

module tb_axis_stream_master;

  localparam int DATA_WIDTH      = 32;
  localparam int START_COUNT     = 5;
  localparam int BURST_WORDS     = 8;
  localparam int HALF_WIDTH      = DATA_WIDTH / 2;
  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 8;
  localparam int RANDOM_BURSTS   = 20;
  localparam int STALL_CYCLES    = 10;
  localparam int WATCHDOG_CYCLES = (START_COUNT + 2 + BURST_WORDS * 4) * 24;

  logic                    M_AXIS_ACLK;
  logic                    M_AXIS_ARESETN;
  logic                    M_AXIS_TVALID;
  logic [DATA_WIDTH-1:0]   M_AXIS_TDATA;
  logic [DATA_WIDTH/8-1:0] M_AXIS_TSTRB;
  logic                    M_AXIS_TLAST;
  logic                    M_AXIS_TREADY;

  // Reference model state advances once per transfer
  logic [HALF_WIDTH-1:0] exp_burst;
  logic [HALF_WIDTH-1:0] exp_idx;
  logic [DATA_WIDTH-1:0] expected_data;
  logic                  expected_last;
  int unsigned           bursts_done;

  assign expected_data = {exp_burst, exp_idx};
  assign expected_last = (exp_idx == HALF_WIDTH'(BURST_WORDS - 1));

  axis_stream_master #(
    .DATA_WIDTH  (DATA_WIDTH),
    .START_COUNT (START_COUNT),
    .BURST_WORDS (BURST_WORDS)
  ) UUT (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .M_AXIS_TVALID  (M_AXIS_TVALID),
    .M_AXIS_TDATA   (M_AXIS_TDATA),
    .M_AXIS_TSTRB   (M_AXIS_TSTRB),
    .M_AXIS_TLAST   (M_AXIS_TLAST),
    .M_AXIS_TREADY  (M_AXIS_TREADY)
  );

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic wait_for_bursts(input int unsigned total);
    while (bursts_done < total) begin
      @(negedge M_AXIS_ACLK);
    end
  endtask

  initial begin
    M_AXIS_ACLK = 1'b0;
    forever #(CLK_PERIOD / 2) M_AXIS_ACLK = ~M_AXIS_ACLK;
  end

  // Outputs are sampled before the edge updates them
  always @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      exp_burst   <= '0;
      exp_idx     <= '0;
      bursts_done <= 0;
    end else if (M_AXIS_TVALID && M_AXIS_TREADY) begin
      assert (M_AXIS_TDATA == expected_data)
        else stop_on_failure($sformatf("[FAIL] M_AXIS_TDATA expected %h actual %h",
                                       expected_data, M_AXIS_TDATA));
      assert (M_AXIS_TLAST == expected_last)
        else stop_on_failure($sformatf("[FAIL] M_AXIS_TLAST expected %h actual %h",
                                       expected_last, M_AXIS_TLAST));
      if (expected_last) begin
        exp_idx     <= '0;
        exp_burst   <= exp_burst + 1'b1;
        bursts_done <= bursts_done + 1;
      end else begin
        exp_idx <= exp_idx + 1'b1;
      end
    end
  end

  initial begin
    wait (UUT.u_props.fail_count != 0);
    stop_on_failure("A stream protocol assertion failed");
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge M_AXIS_ACLK);
    stop_on_failure($sformatf("Timeout: the test did not finish within %0d cycles",
                              WATCHDOG_CYCLES));
  end

  initial begin
    void'($urandom(13));
    M_AXIS_ARESETN = 1'b0;
    M_AXIS_TREADY  = 1'b0;
    repeat (RESET_CYCLES) @(negedge M_AXIS_ACLK);
    M_AXIS_ARESETN = 1'b1;

    // Full rate for the first two bursts
    M_AXIS_TREADY = 1'b1;
    wait_for_bursts(2);

    while (bursts_done < 2 + RANDOM_BURSTS) begin
      @(negedge M_AXIS_ACLK);
      M_AXIS_TREADY = (($urandom % 2) == 1);
    end

    // Long stall in the middle of a burst
    M_AXIS_TREADY = 1'b1;
    @(negedge M_AXIS_ACLK);
    while (exp_idx != HALF_WIDTH'(BURST_WORDS / 2)) begin
      @(negedge M_AXIS_ACLK);
    end
    M_AXIS_TREADY = 1'b0;
    repeat (STALL_CYCLES) @(negedge M_AXIS_ACLK);
    M_AXIS_TREADY = 1'b1;
    wait_for_bursts(bursts_done + 1);

    // Let the idle gap after the final burst be checked
    repeat (START_COUNT + 3) @(negedge M_AXIS_ACLK);

    if (UUT.u_props.fail_count != 0) begin
      stop_on_failure("Assertion failures were recorded during the run");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule
